// ==== common/dispatch_pkg.sv ====
//////////////////////////////
// Widths, ALU codes, opcodes and operand selects shared by the
// dispatch stage. Import with dispatch_pkg::* in the module header
//////////////////////////////

package dispatch_pkg;

    localparam int XLEN      = 32;
    localparam int ROB_DEPTH = 8;
    localparam int TAG_W     = 4;     // Zero tag means value in regfile

    typedef logic [XLEN-1:0]              word_t;
    typedef logic [31:0]                  inst_t;
    typedef logic [4:0]                   reg_idx_t;
    typedef logic [TAG_W-1:0]             tag_t;
    typedef logic [$clog2(ROB_DEPTH)-1:0] rob_idx_t;
    typedef logic [3:0]                   alu_func_t;

    //////////////////////////////
    // ALU function codes
    //////////////////////////////
    localparam alu_func_t ALU_ADD  = 4'h0;
    localparam alu_func_t ALU_SUB  = 4'h1;
    localparam alu_func_t ALU_SLT  = 4'h2;
    localparam alu_func_t ALU_SLTU = 4'h3;
    localparam alu_func_t ALU_AND  = 4'h4;
    localparam alu_func_t ALU_OR   = 4'h5;
    localparam alu_func_t ALU_XOR  = 4'h6;
    localparam alu_func_t ALU_SLL  = 4'h7;
    localparam alu_func_t ALU_SRL  = 4'h8;
    localparam alu_func_t ALU_SRA  = 4'h9;

    // Operand sources
    typedef enum logic [1:0] {
        OPA_IS_RS1,
        OPA_IS_PC,
        OPA_IS_ZERO
    } opa_sel_t;

    typedef enum logic [1:0] {
        OPB_IS_RS2,
        OPB_IS_I_IMM,
        OPB_IS_U_IMM
    } opb_sel_t;

    // Major opcodes of the supported subset
    localparam logic [6:0] OP_LUI   = 7'b0110111;
    localparam logic [6:0] OP_AUIPC = 7'b0010111;
    localparam logic [6:0] OP_IMM   = 7'b0010011;
    localparam logic [6:0] OP_REG   = 7'b0110011;

endpackage

// ==== rtl/decoder.sv ====
//////////////////////////////
// Combinational RV32I subset decoder. Anything outside LUI, AUIPC
// and the ALU groups is flagged illegal while valid is high
//////////////////////////////
`timescale 1ns/1ns

module decoder import dispatch_pkg::*; (
    input  inst_t     inst,
    input  logic      valid,
    output opa_sel_t  opa_select,
    output opb_sel_t  opb_select,
    output alu_func_t alu_func,
    output logic      has_dest,
    output logic      illegal
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        // NOP unless matched below
        opa_select = OPA_IS_RS1;
        opb_select = OPB_IS_RS2;
        alu_func   = ALU_ADD;
        has_dest   = 1'b0;
        illegal    = 1'b0;
        if (valid) begin
            casez ({funct7, funct3, opcode})
                {7'b???????, 3'b???, OP_LUI}: begin
                    opa_select = OPA_IS_ZERO;
                    opb_select = OPB_IS_U_IMM;
                end
                {7'b???????, 3'b???, OP_AUIPC}: begin
                    opa_select = OPA_IS_PC;
                    opb_select = OPB_IS_U_IMM;
                end
                {7'b???????, 3'b000, OP_IMM}, {7'b0000000, 3'b000, OP_REG}: alu_func = ALU_ADD;
                {7'b0100000, 3'b000, OP_REG}: alu_func = ALU_SUB;
                {7'b???????, 3'b010, OP_IMM}, {7'b0000000, 3'b010, OP_REG}: alu_func = ALU_SLT;
                {7'b???????, 3'b011, OP_IMM}, {7'b0000000, 3'b011, OP_REG}: alu_func = ALU_SLTU;
                {7'b???????, 3'b100, OP_IMM}, {7'b0000000, 3'b100, OP_REG}: alu_func = ALU_XOR;
                {7'b???????, 3'b110, OP_IMM}, {7'b0000000, 3'b110, OP_REG}: alu_func = ALU_OR;
                {7'b???????, 3'b111, OP_IMM}, {7'b0000000, 3'b111, OP_REG}: alu_func = ALU_AND;
                {7'b0000000, 3'b001, OP_IMM}, {7'b0000000, 3'b001, OP_REG}: alu_func = ALU_SLL;
                {7'b0000000, 3'b101, OP_IMM}, {7'b0000000, 3'b101, OP_REG}: alu_func = ALU_SRL;
                {7'b0100000, 3'b101, OP_IMM}, {7'b0100000, 3'b101, OP_REG}: alu_func = ALU_SRA;
                default: illegal = 1'b1;   // loads, stores, branches, system
            endcase

            // Immediate group takes opb from the I immediate
            if (opcode == OP_IMM) begin
                opb_select = OPB_IS_I_IMM;
            end
            has_dest = !illegal;   // every supported op writes rd
        end
    end

endmodule

// ==== rtl/map_table.sv ====
//////////////////////////////
// Rename map: one ROB tag and ready bit per architectural register.
// Written at dispatch, marked ready by the CDB, cleared at retire
//////////////////////////////
`timescale 1ns/1ns

module map_table import dispatch_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  logic     rename,
    input  reg_idx_t rename_rd,
    input  tag_t     rename_tag,
    input  logic     cdb_valid,
    input  tag_t     cdb_tag,
    input  logic     retire_valid,
    input  reg_idx_t retire_rd,
    input  tag_t     retire_tag,
    output tag_t     rs1_tag,
    output tag_t     rs2_tag,
    output logic     rs1_ready,
    output logic     rs2_ready
);

    tag_t [31:0] tags;
    logic [31:0] ready;

    assign rs1_tag   = tags[rs1];
    assign rs2_tag   = tags[rs2];
    assign rs1_ready = ready[rs1];
    assign rs2_ready = ready[rs2];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            tags  <= '0;
            ready <= '0;
        end else begin
            for (int r = 0; r < 32; r++) begin
                if (cdb_valid && tags[r] != '0 && tags[r] == cdb_tag) begin
                    ready[r] <= 1'b1;
                end
            end
            // Only clear if no younger rename took the register
            if (retire_valid && tags[retire_rd] == retire_tag) begin
                tags[retire_rd]  <= '0;
                ready[retire_rd] <= 1'b0;
            end
            if (rename) begin                 // last assignment wins over retire
                tags[rename_rd]  <= rename_tag;
                ready[rename_rd] <= 1'b0;
            end
        end
    end

    // x0 must stay at tag zero so its reads always hit the regfile
    a_no_x0_rename: assert property (@(posedge clock) disable iff (!rst_n)
        rename |-> rename_rd != '0);

endmodule

// ==== rob/reorder_buffer.sv ====
//////////////////////////////
// Eight entry reorder buffer. Allocates at the tail on dispatch,
// collects CDB results and retires a finished head in order
//////////////////////////////
`timescale 1ns/1ns

module reorder_buffer import dispatch_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  logic     alloc,
    input  reg_idx_t alloc_rd,
    output tag_t     tail_tag,
    output logic     full,
    input  tag_t     read_tag1,
    input  tag_t     read_tag2,
    output word_t    read_value1,
    output word_t    read_value2,
    input  logic     cdb_valid,
    input  tag_t     cdb_tag,
    input  word_t    cdb_value,
    input  logic     retire,
    output logic     retire_valid,
    output reg_idx_t retire_rd,
    output word_t    retire_value,
    output tag_t     retire_tag
);

    word_t                      values [ROB_DEPTH];
    reg_idx_t                   dest_rd [ROB_DEPTH];
    logic [ROB_DEPTH-1:0]       done;
    rob_idx_t                   head;
    rob_idx_t                   tail;
    logic [$clog2(ROB_DEPTH):0] count;
    rob_idx_t                   cdb_idx;
    rob_idx_t                   cdb_offset;   // distance of the CDB entry from head

    // Tag is index plus one
    assign cdb_idx    = rob_idx_t'(cdb_tag - 1'b1);
    assign cdb_offset = cdb_idx - head;
    assign tail_tag   = tag_t'(tail) + 1'b1;
    assign retire_tag = tag_t'(head) + 1'b1;
    assign full       = (count == ROB_DEPTH);

    assign read_value1 = values[rob_idx_t'(read_tag1 - 1'b1)];
    assign read_value2 = values[rob_idx_t'(read_tag2 - 1'b1)];

    //////////////////////////////
    // Retirement
    //////////////////////////////
    assign retire_valid = retire && count != '0 && done[head];
    assign retire_rd    = dest_rd[head];
    assign retire_value = values[head];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            done  <= '0;
        end else begin
            if (alloc) begin
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            if (cdb_valid) begin
                done[cdb_idx] <= 1'b1;
            end
            if (retire_valid) begin
                head <= head + 1'b1;
            end
            if (alloc && !retire_valid) begin
                count <= count + 1'b1;
            end else if (!alloc && retire_valid) begin
                count <= count - 1'b1;
            end
        end
    end

    // Entry payload
    always_ff @(posedge clock) begin
        if (alloc) begin
            dest_rd[tail] <= alloc_rd;
        end
        if (cdb_valid) begin
            values[cdb_idx] <= cdb_value;
        end
    end

    a_cdb_live_entry: assert property (@(posedge clock) disable iff (!rst_n)
        cdb_valid |-> cdb_tag != '0 && cdb_offset < count);

    a_no_alloc_when_full: assert property (@(posedge clock) disable iff (!rst_n)
        alloc |-> !full);

endmodule

// ==== rtl/regfile.sv ====
//////////////////////////////
// Architectural register file, two async read ports, one write
// port driven by ROB retirement. x0 is never written
//////////////////////////////
`timescale 1ns/1ns

module regfile import dispatch_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  reg_idx_t read_idx1,
    input  reg_idx_t read_idx2,
    output word_t    read_out1,
    output word_t    read_out2,
    input  logic     write_en,
    input  reg_idx_t write_idx,
    input  word_t    write_data
);

    word_t [31:0] regs;

    assign read_out1 = regs[read_idx1];
    assign read_out2 = regs[read_idx2];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            regs <= '0;
        end else if (write_en && write_idx != '0) begin   // x0 stays zero
            regs[write_idx] <= write_data;
        end
    end

endmodule

// ==== rtl/reservation_station.sv ====
//////////////////////////////
// Single entry reservation station. Pending operands carry their
// tag in the low bits until a matching CDB broadcast fills them
//////////////////////////////
`timescale 1ns/1ns

module reservation_station import dispatch_pkg::*; (
    input  logic      clock,
    input  logic      rst_n,
    input  logic      load,
    input  word_t     opa_in,
    input  word_t     opb_in,
    input  logic      opa_valid_in,
    input  logic      opb_valid_in,
    input  alu_func_t func_in,
    input  tag_t      dest_tag_in,
    input  logic      cdb_valid,
    input  tag_t      cdb_tag,
    input  word_t     cdb_value,
    input  logic      issue,
    output logic      available,
    output logic      ready,
    output word_t     opa,
    output word_t     opb,
    output alu_func_t alu_func,
    output tag_t      dest_tag
);

    logic busy;
    logic opa_ok;
    logic opb_ok;
    logic opa_wake;
    logic opb_wake;

    // Snoop the CDB for the awaited tags
    assign opa_wake  = busy && !opa_ok && cdb_valid && opa[TAG_W-1:0] == cdb_tag;
    assign opb_wake  = busy && !opb_ok && cdb_valid && opb[TAG_W-1:0] == cdb_tag;
    assign available = !busy;
    assign ready     = busy && opa_ok && opb_ok;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            opa_ok <= 1'b0;
            opb_ok <= 1'b0;
        end else if (load) begin
            busy   <= 1'b1;
            opa_ok <= opa_valid_in;
            opb_ok <= opb_valid_in;
        end else begin
            if (issue) busy <= 1'b0;      // frees at the issue edge
            if (opa_wake) opa_ok <= 1'b1;
            if (opb_wake) opb_ok <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            opa      <= opa_in;
            opb      <= opb_in;
            alu_func <= func_in;
            dest_tag <= dest_tag_in;
        end else begin
            if (opa_wake) opa <= cdb_value;
            if (opb_wake) opb <= cdb_value;
        end
    end

    a_issue_when_ready: assert property (@(posedge clock) disable iff (!rst_n)
        issue |-> ready);

endmodule

// ==== rtl/stage_id.sv ====
//////////////////////////////
// Dispatch stage top. Decodes, renames through the map table and
// loads the reservation station while allocating a ROB entry
//////////////////////////////
`timescale 1ns/1ns

module stage_id import dispatch_pkg::*; (
    input  logic      clock,
    input  logic      rst_n,
    input  logic      inst_valid,
    input  inst_t     inst,
    input  word_t     pc,
    output logic      accept,
    output logic      illegal,
    input  logic      cdb_valid,
    input  tag_t      cdb_tag,
    input  word_t     cdb_value,
    input  logic      issue,
    output logic      rs_ready,
    output word_t     opa,
    output word_t     opb,
    output alu_func_t alu_func,
    output tag_t      issue_tag,
    input  logic      retire,
    output logic      retire_valid,
    output reg_idx_t  retire_rd,
    output word_t     retire_value
);

    opa_sel_t    opa_select;
    opb_sel_t    opb_select;
    alu_func_t   dec_func;
    logic        has_dest;
    reg_idx_t    dest_rd;
    tag_t        rs1_tag, rs2_tag, tail_tag, retire_tag;
    logic        rs1_ready, rs2_ready;
    word_t       rf_value1, rf_value2, rob_value1, rob_value2;
    logic        rob_full, rs_available;
    logic [XLEN:0] rs1_src, rs2_src;   // {valid, value or tag}
    word_t       opa_in, opb_in;
    logic        opa_valid_in, opb_valid_in;

    // Regfile, then finished ROB entry, then same-cycle CDB, else wait on tag
    function automatic logic [XLEN:0] source_operand(tag_t tag, logic tag_ready,
                                                     word_t rf_val, word_t rob_val);
        if (tag == '0) return {1'b1, rf_val};
        if (tag_ready) return {1'b1, rob_val};
        if (cdb_valid && cdb_tag == tag) return {1'b1, cdb_value};
        return {1'b0, word_t'(tag)};
    endfunction

    always_comb begin
        rs1_src = source_operand(rs1_tag, rs1_ready, rf_value1, rob_value1);
        rs2_src = source_operand(rs2_tag, rs2_ready, rf_value2, rob_value2);
    end

    always_comb begin
        case (opa_select)
            OPA_IS_PC:   opa_in = pc;
            OPA_IS_ZERO: opa_in = '0;
            default:     opa_in = rs1_src[XLEN-1:0];
        endcase
        case (opb_select)
            OPB_IS_I_IMM: opb_in = {{20{inst[31]}}, inst[31:20]};
            OPB_IS_U_IMM: opb_in = {inst[31:12], 12'b0};
            default:      opb_in = rs2_src[XLEN-1:0];
        endcase
    end

    assign opa_valid_in = (opa_select != OPA_IS_RS1) || rs1_src[XLEN];
    assign opb_valid_in = (opb_select != OPB_IS_RS2) || rs2_src[XLEN];
    assign dest_rd      = has_dest ? inst[11:7] : '0;
    assign accept       = inst_valid && !illegal && rs_available && !rob_full;

    decoder decoder_0 (
        .inst(inst), .valid(inst_valid), .opa_select(opa_select), .opb_select(opb_select),
        .alu_func(dec_func), .has_dest(has_dest), .illegal(illegal)
    );

    map_table map_table_0 (
        .clock(clock), .rst_n(rst_n), .rs1(inst[19:15]), .rs2(inst[24:20]),
        .rename(accept && dest_rd != '0), .rename_rd(dest_rd), .rename_tag(tail_tag),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .retire_valid(retire_valid),
        .retire_rd(retire_rd), .retire_tag(retire_tag), .rs1_tag(rs1_tag),
        .rs2_tag(rs2_tag), .rs1_ready(rs1_ready), .rs2_ready(rs2_ready)
    );

    reorder_buffer reorder_buffer_0 (
        .clock(clock), .rst_n(rst_n), .alloc(accept), .alloc_rd(dest_rd),
        .tail_tag(tail_tag), .full(rob_full), .read_tag1(rs1_tag), .read_tag2(rs2_tag),
        .read_value1(rob_value1), .read_value2(rob_value2), .cdb_valid(cdb_valid),
        .cdb_tag(cdb_tag), .cdb_value(cdb_value), .retire(retire),
        .retire_valid(retire_valid), .retire_rd(retire_rd), .retire_value(retire_value),
        .retire_tag(retire_tag)
    );

    regfile regfile_0 (
        .clock(clock), .rst_n(rst_n), .read_idx1(inst[19:15]), .read_idx2(inst[24:20]),
        .read_out1(rf_value1), .read_out2(rf_value2), .write_en(retire_valid),
        .write_idx(retire_rd), .write_data(retire_value)
    );

    reservation_station reservation_station_0 (
        .clock(clock), .rst_n(rst_n), .load(accept), .opa_in(opa_in), .opb_in(opb_in),
        .opa_valid_in(opa_valid_in), .opb_valid_in(opb_valid_in), .func_in(dec_func),
        .dest_tag_in(tail_tag), .cdb_valid(cdb_valid), .cdb_tag(cdb_tag),
        .cdb_value(cdb_value), .issue(issue), .available(rs_available), .ready(rs_ready),
        .opa(opa), .opb(opb), .alu_func(alu_func), .dest_tag(issue_tag)
    );

endmodule

// ==== sim/stage_id_tb.sv ====
//////////////////////////////
// Testbench for the dispatch stage. Applies a table of instructions,
// plays the functional unit on the CDB and retires against a register model
//////////////////////////////
`timescale 1ns/1ns

module stage_id_tb import dispatch_pkg::*; ();

    localparam int ROWS        = 24;
    localparam int CYCLE_LIMIT = 40 * ROWS;

    typedef struct packed {
        int        row;
        int        seq;
        int        src1;        // Producer sequence number or -1
        int        src2;
        word_t     opa;
        word_t     opb;
        alu_func_t func;
        tag_t      tag;
        reg_idx_t  rd;
        word_t     result;
    } entry_t;

    logic      clock, rst_n;
    logic      inst_valid, accept, illegal;
    inst_t     inst;
    word_t     pc;
    logic      cdb_valid;
    tag_t      cdb_tag;
    word_t     cdb_value;
    logic      issue, rs_ready;
    word_t     opa, opb;
    alu_func_t alu_func;
    tag_t      issue_tag;
    logic      retire, retire_valid;
    reg_idx_t  retire_rd;
    word_t     retire_value;

    // Stimulus table
    string     row_name [ROWS];
    inst_t     row_inst [ROWS];
    word_t     row_pc   [ROWS];
    logic      row_ill  [ROWS];
    int        row_errs [ROWS];
    int        rows_added;

    word_t     model_regs [32];
    int        last_writer [32];
    entry_t    issue_q [$];
    entry_t    retire_q [$];
    integer    seed;
    int        dispatched, retired, error_count, tests_passed, tests_failed, cycles;
    logic      rs_occupied;

    stage_id stage_id_i (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    task automatic wait_cycle();
        @(posedge clock);
        #2;
    endtask

    task automatic mismatch(int row, string what, word_t expected, word_t actual);
        $display("[FAIL] %s %s expected %h actual %h", row_name[row], what, expected, actual);
        error_count++;
        row_errs[row]++;
    endtask

    task automatic note_error(int row, string text);
        if (row >= 0) begin
            $display("ERROR %s: %s", row_name[row], text);
            row_errs[row]++;
        end else begin
            $display("ERROR %s", text);
        end
        error_count++;
    endtask

    task automatic report_test(int row);
        if (row_errs[row] == 0) begin
            tests_passed++;
            $display("test %s ok", row_name[row]);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", row_name[row], row_errs[row]);
        end
    endtask

    function automatic inst_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                    reg_idx_t rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic inst_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3, reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic inst_t enc_u(logic [19:0] imm, reg_idx_t rd, logic [6:0] op);
        return {imm, rd, op};
    endfunction

    task automatic add_row(string name, inst_t ins, logic ill);
        row_name[rows_added] = name;
        row_inst[rows_added] = ins;
        row_pc[rows_added]   = 32'h100 + 32'(rows_added * 4);
        row_ill[rows_added]  = ill;
        row_errs[rows_added] = 0;
        rows_added++;
    endtask

    //////////////////////////////
    // Reference model
    //////////////////////////////
    function automatic word_t alu_ref(alu_func_t f, word_t a, word_t b);
        case (f)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLT:  return word_t'($signed(a) < $signed(b));
            ALU_SLTU: return word_t'(a < b);
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return $signed(a) >>> b[4:0];   // shift amount is low five bits
            default:  return '0;
        endcase
    endfunction

    function automatic entry_t predict(int row, inst_t ins, word_t p);
        entry_t     e;
        logic [6:0] op;
        op     = ins[6:0];
        e.row  = row;
        e.seq  = dispatched;
        e.tag  = tag_t'(dispatched % ROB_DEPTH + 1);   // tail index plus one
        e.rd   = ins[11:7];
        e.src1 = (op == OP_IMM || op == OP_REG) ? last_writer[ins[19:15]] : -1;
        e.src2 = (op == OP_REG) ? last_writer[ins[24:20]] : -1;
        if (op == OP_LUI) e.opa = '0;
        else if (op == OP_AUIPC) e.opa = p;
        else e.opa = model_regs[ins[19:15]];
        if (op == OP_REG) e.opb = model_regs[ins[24:20]];
        else if (op == OP_IMM) e.opb = word_t'($signed(ins[31:20]));
        else e.opb = ins & 32'hffff_f000;
        case (ins[14:12])
            3'd0:    e.func = (op == OP_REG && ins[30]) ? ALU_SUB : ALU_ADD;
            3'd1:    e.func = ALU_SLL;
            3'd2:    e.func = ALU_SLT;
            3'd3:    e.func = ALU_SLTU;
            3'd4:    e.func = ALU_XOR;
            3'd5:    e.func = ins[30] ? ALU_SRA : ALU_SRL;
            3'd6:    e.func = ALU_OR;
            default: e.func = ALU_AND;
        endcase
        if (op == OP_LUI || op == OP_AUIPC) e.func = ALU_ADD;
        e.result = alu_ref(e.func, e.opa, e.opb);
        return e;
    endfunction

    //////////////////////////////
    // Dispatch side and end of run
    //////////////////////////////
    initial begin : dispatch_side
        entry_t e;
        logic   exp_accept;
        logic   taken;
        seed        = 12336;
        rst_n       = 1'b0;
        inst_valid  = 1'b0;
        inst        = '0;
        pc          = '0;
        cdb_valid   = 1'b0;
        cdb_tag     = '0;
        cdb_value   = '0;
        issue       = 1'b0;
        retire      = 1'b0;
        rs_occupied = 1'b0;
        rows_added  = 0;
        dispatched  = 0;
        retired     = 0;
        error_count = 0;
        tests_passed = 0;
        tests_failed = 0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r]  = '0;
            last_writer[r] = -1;
        end
        add_row("lui_x1",      enc_u(20'h12345, 5'd1, OP_LUI), 1'b0);
        add_row("auipc_x2",    enc_u(20'h00010, 5'd2, OP_AUIPC), 1'b0);
        add_row("addi_neg",    enc_i(12'hffb, 5'd0, 3'd0, 5'd3, OP_IMM), 1'b0);
        add_row("srai_chain",  enc_i(12'h401, 5'd3, 3'd5, 5'd4, OP_IMM), 1'b0);
        add_row("add_x5",      enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd5), 1'b0);
        add_row("sub_chain",   enc_r(7'h20, 5'd3, 5'd5, 3'd0, 5'd6), 1'b0);
        add_row("lw_illegal",  enc_i(12'h000, 5'd1, 3'd2, 5'd7, 7'b0000011), 1'b1);
        add_row("slt_x7",      enc_r(7'h00, 5'd0, 5'd3, 3'd2, 5'd7), 1'b0);
        add_row("sltu_x8",     enc_r(7'h00, 5'd0, 5'd3, 3'd3, 5'd8), 1'b0);
        add_row("xori_x9",     enc_i(12'h0ff, 5'd1, 3'd4, 5'd9, OP_IMM), 1'b0);
        add_row("sw_illegal",  enc_i(12'h004, 5'd2, 3'd2, 5'd4, 7'b0100011), 1'b1);
        add_row("or_x10",      enc_r(7'h00, 5'd6, 5'd9, 3'd6, 5'd10), 1'b0);
        add_row("and_x11",     enc_r(7'h00, 5'd5, 5'd10, 3'd7, 5'd11), 1'b0);
        add_row("slli_x12",    enc_i(12'h004, 5'd11, 3'd1, 5'd12, OP_IMM), 1'b0);
        add_row("srl_x13",     enc_r(7'h00, 5'd7, 5'd3, 3'd5, 5'd13), 1'b0);
        add_row("beq_illegal", enc_i(12'h000, 5'd1, 3'd0, 5'd8, 7'b1100011), 1'b1);
        add_row("sll_x14",     enc_r(7'h00, 5'd7, 5'd1, 3'd1, 5'd14), 1'b0);
        add_row("sra_x15",     enc_r(7'h20, 5'd7, 5'd3, 3'd5, 5'd15), 1'b0);
        add_row("andi_x16",    enc_i(12'h7f0, 5'd15, 3'd7, 5'd16, OP_IMM), 1'b0);
        add_row("ori_x17",     enc_i(12'hfff, 5'd0, 3'd6, 5'd17, OP_IMM), 1'b0);
        add_row("sltiu_x18",   enc_i(12'hfff, 5'd3, 3'd3, 5'd18, OP_IMM), 1'b0);
        add_row("slti_x19",    enc_i(12'hffc, 5'd3, 3'd2, 5'd19, OP_IMM), 1'b0);
        add_row("addi_x0",     enc_i(12'h005, 5'd1, 3'd0, 5'd0, OP_IMM), 1'b0);
        add_row("add_x20",     enc_r(7'h00, 5'd3, 5'd3, 3'd0, 5'd20), 1'b0);

        repeat (5) @(posedge clock);
        #2;
        rst_n = 1'b1;

        for (int i = 0; i < ROWS; i++) begin
            inst_valid = 1'b1;
            inst       = row_inst[i];
            pc         = row_pc[i];
            if (row_ill[i]) begin
                @(negedge clock);
                if (!illegal || accept) begin
                    note_error(i, "illegal instruction was not flagged or was accepted");
                end
                report_test(i);
                wait_cycle;
            end else begin
                taken = 1'b0;
                while (!taken) begin
                    @(negedge clock);
                    // Busy station or full ROB holds the instruction
                    exp_accept = !rs_occupied && (dispatched - retired) < ROB_DEPTH;
                    if (illegal) begin
                        note_error(i, "supported instruction was flagged illegal");
                    end
                    if (accept !== exp_accept) begin
                        mismatch(i, "accept", word_t'(exp_accept), word_t'(accept));
                    end
                    if (accept) begin
                        e = predict(i, row_inst[i], row_pc[i]);
                        issue_q.push_back(e);
                        retire_q.push_back(e);
                        if (e.rd != 5'd0) begin
                            model_regs[e.rd]  = e.result;
                            last_writer[e.rd] = e.seq;
                        end
                        taken = 1'b1;
                    end
                    wait_cycle;
                end
                dispatched++;
                rs_occupied = 1'b1;
            end
        end
        inst_valid = 1'b0;

        while (retired < dispatched) wait_cycle;
        if (tests_passed + tests_failed != ROWS) begin
            note_error(-1, "not every test reached its end");
        end
        $display("Tests: %0d passed, %0d failed, %0d errors",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    //////////////////////////////
    // Functional unit
    //////////////////////////////
    initial begin : functional_unit
        entry_t cur;
        tag_t   bc_tag;
        int     d;
        wait (rst_n === 1'b1);
        forever begin
            @(negedge clock);
            if (rs_ready && issue_q.size() == 0) begin
                note_error(-1, "station ready with nothing dispatched");
            end else if (rs_ready) begin
                cur    = issue_q.pop_front();
                bc_tag = issue_tag;
                if (opa !== cur.opa) mismatch(cur.row, "opa", cur.opa, opa);
                if (opb !== cur.opb) mismatch(cur.row, "opb", cur.opb, opb);
                if (alu_func !== cur.func) begin
                    mismatch(cur.row, "alu_func", word_t'(cur.func), word_t'(alu_func));
                end
                if (issue_tag !== cur.tag) begin
                    mismatch(cur.row, "issue_tag", word_t'(cur.tag), word_t'(issue_tag));
                end
                wait_cycle;
                issue = 1'b1;
                wait_cycle;
                issue       = 1'b0;
                rs_occupied = 1'b0;           // station freed at that edge
                d = $random(seed) & 3;
                for (int w = 0; w < d; w++) begin
                    @(negedge clock);
                    // Consumer of this result must still wait
                    if (rs_ready && issue_q.size() > 0 &&
                        (issue_q[0].src1 == cur.seq || issue_q[0].src2 == cur.seq)) begin
                        note_error(issue_q[0].row, "operand woke before its CDB broadcast");
                    end
                    wait_cycle;
                end
                cdb_valid = 1'b1;
                cdb_tag   = bc_tag;
                cdb_value = cur.result;
                wait_cycle;
                cdb_valid = 1'b0;
            end
        end
    end

    //////////////////////////////
    // Retirement
    //////////////////////////////
    initial begin : retire_side
        entry_t r;
        int     d;
        logic   seen;
        wait (rst_n === 1'b1);
        forever begin
            wait_cycle;
            d = $random(seed) & 3;     // lets finished results sit in the ROB
            repeat (d) wait_cycle;
            retire = 1'b1;
            seen   = 1'b0;
            while (!seen) begin
                @(negedge clock);
                if (retire_valid && retire_q.size() == 0) begin
                    seen = 1'b1;
                    note_error(-1, "retirement with no instruction in flight");
                end else if (retire_valid) begin
                    seen = 1'b1;
                    r    = retire_q.pop_front();
                    if (retire_rd !== r.rd) begin
                        mismatch(r.row, "retire_rd", word_t'(r.rd), word_t'(retire_rd));
                    end
                    if (retire_value !== r.result) begin
                        mismatch(r.row, "retire_value", r.result, retire_value);
                    end
                    report_test(r.row);
                end
                wait_cycle;
            end
            retire = 1'b0;
            retired++;
        end
    end

    // Run limit
    initial begin : watchdog
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clock);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Verification failed");
        $finish;
    end

endmodule

// ==== dispatch.f ====
common/dispatch_pkg.sv
rtl/decoder.sv
rtl/map_table.sv
rob/reorder_buffer.sv
rtl/regfile.sv
rtl/reservation_station.sv
rtl/stage_id.sv
sim/stage_id_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the dispatch stage testbench with Verilator, runs it and
# scans the log for the failure message
set -o pipefail
cd "$(dirname "$0")" || exit 1
LOG=sim.log
verilator --binary --timing --assert -Wno-fatal --top-module stage_id_tb \
    -f dispatch.f -Mdir obj_dir -o stage_id_sim &&
    ./obj_dir/stage_id_sim 2>&1 | tee "$LOG" &&
    ! grep -q "Verification failed" "$LOG" &&
    echo "run_sim: simulation clean" ||
    { echo "run_sim: simulation failed"; exit 1; }
